// ==== design/fb_params.svh ====
`ifndef FB_PARAMS_SVH
`define FB_PARAMS_SVH

// visible frame size in pixels per line and lines per frame.
`define FB_WIDTH      16
`define FB_HEIGHT     8

// total clocks per line and lines per frame including blanking.
`define H_TOTAL       20
`define V_TOTAL       10

// syncs are active low from start up to but not including end.
`define H_SYNC_START  17
`define H_SYNC_END    19
`define V_SYNC_START  8
`define V_SYNC_END    9

`define ADDR_BITS     20
`define DATA_BITS     16

`endif

// ==== design/fb_pkg.sv ====
`include "fb_params.svh"

package fb_pkg;

  // colour layout of one framebuffer word with the top nibble unused.
  typedef struct packed {
    logic [3:0] unused;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb444_t;

  // the SRAM side moves raw words; the renderer and scanout use the colour view.
  typedef union packed {
    logic [`DATA_BITS-1:0] raw;
    rgb444_t               rgb;
  } pixel_word_u;

endpackage

// ==== design/mem_port_if.sv ====
`include "fb_params.svh"

// one SRAM access port. a write happens on every clock with we high,
// and read data for an address shows up on the following clock.
interface mem_port_if;
  import fb_pkg::*;

  logic [`ADDR_BITS-1:0] addr;
  pixel_word_u           wdata;
  logic                  we;
  pixel_word_u           rdata;

  modport requester (
    output addr,
    output wdata,
    output we,
    input  rdata
  );

  modport swapper (
    input  addr,
    input  wdata,
    input  we,
    output rdata
  );

endinterface

// ==== design/pattern_renderer.sv ====
`include "fb_params.svh"

module pattern_renderer (
  input  logic          clk,
  input  logic          rst,
  input  logic          hold,
  input  logic          frame_start,
  output logic          frame_done,
  mem_port_if.requester mem
);
  import fb_pkg::*;

  localparam int X_BITS = $clog2(`FB_WIDTH);
  localparam int Y_BITS = $clog2(`FB_HEIGHT);
  localparam int AW     = `ADDR_BITS;

  logic [X_BITS-1:0] x_cnt;
  logic [Y_BITS-1:0] y_cnt;
  logic [3:0]        frame_num;
  logic              drawing;
  logic              advance;
  logic              last_x;
  logic              last_pixel;
  pixel_word_u       pixel;

  assign advance    = drawing && !hold;
  assign last_x     = (x_cnt == X_BITS'(`FB_WIDTH - 1));
  assign last_pixel = last_x && (y_cnt == Y_BITS'(`FB_HEIGHT - 1));

  // pattern colour for the current position and frame number.
  always_comb begin
    pixel           = '0;
    pixel.rgb.red   = 4'(x_cnt) + frame_num;
    pixel.rgb.green = 4'(y_cnt);
    pixel.rgb.blue  = frame_num;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      x_cnt      <= '0;
      y_cnt      <= '0;
      frame_num  <= '0;
      drawing    <= 1'b1;
      frame_done <= 1'b0;
      mem.we     <= 1'b0;
    end else begin
      mem.we <= advance;
      if (frame_start) begin
        x_cnt      <= '0;
        y_cnt      <= '0;
        frame_num  <= frame_num + 4'd1;
        drawing    <= 1'b1;
        frame_done <= 1'b0;
      end else if (advance) begin
        if (last_pixel) begin
          // done goes up together with the final write strobe.
          x_cnt      <= '0;
          y_cnt      <= '0;
          drawing    <= 1'b0;
          frame_done <= 1'b1;
        end else if (last_x) begin
          x_cnt <= '0;
          y_cnt <= y_cnt + 1'b1;
        end else begin
          x_cnt <= x_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    mem.addr  <= AW'(y_cnt) * AW'(`FB_WIDTH) + AW'(x_cnt);
    mem.wdata <= pixel;
  end

endmodule

// ==== design/scanout.sv ====
`include "fb_params.svh"

module scanout (
  input  logic          clk,
  input  logic          rst,
  output logic          frame_end,
  mem_port_if.requester mem,
  output logic [3:0]    vga_red,
  output logic [3:0]    vga_grn,
  output logic [3:0]    vga_blu,
  output logic          vga_hsync,
  output logic          vga_vsync
);

  localparam int H_BITS = $clog2(`H_TOTAL);
  localparam int V_BITS = $clog2(`V_TOTAL);
  localparam int AW     = `ADDR_BITS;

  logic [H_BITS-1:0] h_cnt;
  logic [V_BITS-1:0] v_cnt;
  logic              last_h;
  logic              visible;
  logic              hsync_raw;
  logic              vsync_raw;
  logic              visible_d1;
  logic              hsync_d1;
  logic              vsync_d1;

  assign last_h    = (h_cnt == H_BITS'(`H_TOTAL - 1));
  assign frame_end = last_h && (v_cnt == V_BITS'(`V_TOTAL - 1));

  assign visible   = (h_cnt < H_BITS'(`FB_WIDTH)) && (v_cnt < V_BITS'(`FB_HEIGHT));
  assign hsync_raw = !((h_cnt >= H_BITS'(`H_SYNC_START)) && (h_cnt < H_BITS'(`H_SYNC_END)));
  assign vsync_raw = !((v_cnt >= V_BITS'(`V_SYNC_START)) && (v_cnt < V_BITS'(`V_SYNC_END)));

  // read-only port on the front buffer.
  assign mem.we    = 1'b0;
  assign mem.wdata = '0;
  assign mem.addr  = visible ? AW'(v_cnt) * AW'(`FB_WIDTH) + AW'(h_cnt) : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (last_h) begin
      h_cnt <= '0;
      v_cnt <= frame_end ? '0 : v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // first stage waits out the SRAM read.
  always_ff @(posedge clk) begin
    if (rst) begin
      visible_d1 <= 1'b0;
      hsync_d1   <= 1'b1;
      vsync_d1   <= 1'b1;
    end else begin
      visible_d1 <= visible;
      hsync_d1   <= hsync_raw;
      vsync_d1   <= vsync_raw;
    end
  end

  // second stage registers colour and syncs together.
  always_ff @(posedge clk) begin
    if (rst) begin
      vga_red   <= 4'h0;
      vga_grn   <= 4'h0;
      vga_blu   <= 4'h0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
    end else begin
      vga_red   <= visible_d1 ? mem.rdata.rgb.red : 4'h0;
      vga_grn   <= visible_d1 ? mem.rdata.rgb.green : 4'h0;
      vga_blu   <= visible_d1 ? mem.rdata.rgb.blue : 4'h0;
      vga_hsync <= hsync_d1;
      vga_vsync <= vsync_d1;
    end
  end

endmodule

// ==== design/frame_swapper.sv ====
`include "fb_params.svh"

module frame_swapper (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  frame_done,
  input  logic                  frame_end,
  output logic                  frame_start,
  output logic                  swap,
  mem_port_if.swapper           render,
  mem_port_if.swapper           scan,
  output logic [`ADDR_BITS-1:0] sram0_addr,
  output fb_pkg::pixel_word_u   sram0_din,
  input  fb_pkg::pixel_word_u   sram0_dout,
  output logic                  sram0_we_n,
  output logic [`ADDR_BITS-1:0] sram1_addr,
  output fb_pkg::pixel_word_u   sram1_din,
  input  fb_pkg::pixel_word_u   sram1_dout,
  output logic                  sram1_we_n
);

  // front selects the displayed bank and the other bank is drawn into.
  logic front;
  logic front_d1;
  logic do_swap;

  assign do_swap = frame_end && frame_done;

  always_ff @(posedge clk) begin
    if (rst) begin
      front       <= 1'b0;
      front_d1    <= 1'b0;
      swap        <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      swap        <= do_swap;
      frame_start <= do_swap;
      front_d1    <= front;
      if (do_swap) begin
        front <= ~front;
      end
    end
  end

  assign sram0_addr = front ? render.addr : scan.addr;
  assign sram1_addr = front ? scan.addr : render.addr;
  assign sram0_din  = render.wdata;
  assign sram1_din  = render.wdata;
  assign sram0_we_n = !(front && render.we);
  assign sram1_we_n = !(!front && render.we);

  // read data belongs to the bank that was front when the address went out.
  assign scan.rdata   = front_d1 ? sram1_dout : sram0_dout;
  assign render.rdata = '0;

endmodule

// ==== design/dbuf_display.sv ====
`include "fb_params.svh"

module dbuf_display (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  hold,
  output logic                  swap,

  output logic [3:0]            vga_red,
  output logic [3:0]            vga_grn,
  output logic [3:0]            vga_blu,
  output logic                  vga_hsync,
  output logic                  vga_vsync,

  output logic [`ADDR_BITS-1:0] sram0_addr,
  output logic [`DATA_BITS-1:0] sram0_din,
  input  logic [`DATA_BITS-1:0] sram0_dout,
  output logic                  sram0_we_n,

  output logic [`ADDR_BITS-1:0] sram1_addr,
  output logic [`DATA_BITS-1:0] sram1_din,
  input  logic [`DATA_BITS-1:0] sram1_dout,
  output logic                  sram1_we_n
);

  logic frame_done;
  logic frame_start;
  logic frame_end;

  mem_port_if render_port ();
  mem_port_if scan_port ();

  pattern_renderer u_renderer (
    .clk        (clk),
    .rst        (rst),
    .hold       (hold),
    .frame_start(frame_start),
    .frame_done (frame_done),
    .mem        (render_port.requester)
  );

  scanout u_scanout (
    .clk      (clk),
    .rst      (rst),
    .frame_end(frame_end),
    .mem      (scan_port.requester),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync)
  );

  frame_swapper u_swapper (
    .clk        (clk),
    .rst        (rst),
    .frame_done (frame_done),
    .frame_end  (frame_end),
    .frame_start(frame_start),
    .swap       (swap),
    .render     (render_port.swapper),
    .scan       (scan_port.swapper),
    .sram0_addr (sram0_addr),
    .sram0_din  (sram0_din),
    .sram0_dout (sram0_dout),
    .sram0_we_n (sram0_we_n),
    .sram1_addr (sram1_addr),
    .sram1_din  (sram1_din),
    .sram1_dout (sram1_dout),
    .sram1_we_n (sram1_we_n)
  );

endmodule

// ==== tests/sram_model.sv ====
`include "fb_params.svh"

// behavioural SRAM bank whose registered read data arrives one clock after the address.
module sram_model #(
  parameter int DEPTH = 256
) (
  input  logic                  clk,
  input  logic [`ADDR_BITS-1:0] addr,
  input  logic [`DATA_BITS-1:0] din,
  output logic [`DATA_BITS-1:0] dout,
  input  logic                  we_n
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IDX_BITS = $clog2(DEPTH);

  // powers up cleared, so the first displayed frame is black.
  logic [`DATA_BITS-1:0] mem [DEPTH] = '{default: '0};
  logic [`DATA_BITS-1:0] rd_data = '0;

  assign dout = rd_data;

  always @(posedge clk) begin
    if (!we_n) begin
      mem[addr[IDX_BITS-1:0]] <= din;
    end
    rd_data <= mem[addr[IDX_BITS-1:0]];
  end

endmodule

// ==== tests/dbuf_display_properties.sv ====
module dbuf_display_properties (
  input logic clk,
  input logic rst,
  input logic swap,
  input logic frame_start,
  input logic frame_end,
  input logic sram0_we_n,
  input logic sram1_we_n
);
  timeunit 1ns;
  timeprecision 1ps;

  swap_single: assert property (@(posedge clk) disable iff (rst) swap |=> !swap)
    else $error("swap stayed high for more than one clock");

  start_single: assert property (@(posedge clk) disable iff (rst) frame_start |=> !frame_start)
    else $error("frame_start stayed high for more than one clock");

  // a swap is the registered answer to frame_end on the clock before.
  swap_after_end: assert property (@(posedge clk) disable iff (rst) swap |-> $past(frame_end))
    else $error("swap pulse without a preceding frame_end");

  we_idle_in_reset: assert property (@(posedge clk)
    rst && $past(rst) |-> sram0_we_n && sram1_we_n)
    else $error("SRAM write enable active during reset");

endmodule

bind dbuf_display dbuf_display_properties props0 (
  .clk        (clk),
  .rst        (rst),
  .swap       (swap),
  .frame_start(frame_start),
  .frame_end  (frame_end),
  .sram0_we_n (sram0_we_n),
  .sram1_we_n (sram1_we_n)
);

// ==== tests/dbuf_display_tb.sv ====
`include "fb_params.svh"

module dbuf_display_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS        = 20;
  localparam int FRAME_CLKS    = `H_TOTAL * `V_TOTAL;
  localparam int FRAMES_TESTED = 15;

  logic                  clk;
  logic                  rst;
  logic                  hold;
  logic                  swap;
  logic [3:0]            vga_red;
  logic [3:0]            vga_grn;
  logic [3:0]            vga_blu;
  logic                  vga_hsync;
  logic                  vga_vsync;
  logic [`ADDR_BITS-1:0] sram0_addr;
  logic [`DATA_BITS-1:0] sram0_din;
  logic [`DATA_BITS-1:0] sram0_dout;
  logic                  sram0_we_n;
  logic [`ADDR_BITS-1:0] sram1_addr;
  logic [`DATA_BITS-1:0] sram1_din;
  logic [`DATA_BITS-1:0] sram1_dout;
  logic                  sram1_we_n;

  int error_count = 0;
  int check_count = 0;
  int swap_count  = 0;
  int h_pos;
  int v_pos;
  int hist_h [2];
  int hist_v [2];
  int hist_n [2];
  bit hist_ok [2] = '{1'b0, 1'b0};

  dbuf_display dut0 (.*);

  sram_model bank0 (.clk(clk), .addr(sram0_addr), .din(sram0_din),
                    .dout(sram0_dout), .we_n(sram0_we_n));
  sram_model bank1 (.clk(clk), .addr(sram1_addr), .din(sram1_din),
                    .dout(sram1_dout), .we_n(sram1_we_n));

  // pattern colour {red, green, blue} of pixel (x, y) in frame number n.
  function automatic logic [11:0] expected_pixel(int x, int y, int n);
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    red   = 4'((x + n) % 16);
    green = 4'(y % 16);
    blue  = 4'(n % 16);
    return {red, green, blue};
  endfunction

  task automatic check_output(int x, int y, int n);
    logic [11:0] got;
    logic [11:0] want;
    logic        visible;
    logic        hs_want;
    logic        vs_want;
    got     = {vga_red, vga_grn, vga_blu};
    visible = (x < `FB_WIDTH) && (y < `FB_HEIGHT);
    want    = visible ? expected_pixel(x, y, n - 1) : 12'h000;
    hs_want = !(x >= `H_SYNC_START && x < `H_SYNC_END);
    vs_want = !(y >= `V_SYNC_START && y < `V_SYNC_END);
    // until the first swap the display shows the cleared SRAM.
    if (!visible || n > 0) begin
      check_count++;
      assert (got == want) else begin
        error_count++;
        $display("[ERROR] vga_rgb at x=%0d y=%0d: got 0x%03h, expected 0x%03h", x, y, got, want);
      end
    end
    check_count += 2;
    assert (vga_hsync == hs_want) else begin
      error_count++;
      $display("[ERROR] vga_hsync at x=%0d y=%0d: got 0x%0h, expected 0x%0h",
               x, y, vga_hsync, hs_want);
    end
    assert (vga_vsync == vs_want) else begin
      error_count++;
      $display("[ERROR] vga_vsync at x=%0d y=%0d: got 0x%0h, expected 0x%0h",
               x, y, vga_vsync, vs_want);
    end
  endtask

  task automatic wait_swaps(int count);
    repeat (count) begin
      @(negedge clk);
      while (!swap) @(negedge clk);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // raster position as defined by the frame geometry.
  always @(posedge clk) begin
    if (rst) begin
      h_pos <= 0;
      v_pos <= 0;
    end else if (h_pos == `H_TOTAL - 1) begin
      h_pos <= 0;
      v_pos <= (v_pos == `V_TOTAL - 1) ? 0 : v_pos + 1;
    end else begin
      h_pos <= h_pos + 1;
    end
  end

  // outputs seen now belong to the raster position of two clocks ago.
  always @(negedge clk) begin
    if (swap) begin
      swap_count++;
    end
    if (rst) begin
      hist_ok[0] = 1'b0;
      hist_ok[1] = 1'b0;
    end else begin
      if (hist_ok[1]) begin
        check_output(hist_h[1], hist_v[1], hist_n[1]);
      end
      hist_h[1]  = hist_h[0];
      hist_v[1]  = hist_v[0];
      hist_n[1]  = hist_n[0];
      hist_ok[1] = hist_ok[0];
      hist_h[0]  = h_pos;
      hist_v[0]  = v_pos;
      hist_n[0]  = swap_count;
      hist_ok[0] = 1'b1;
    end
  end

  initial begin
    int swaps_before;
    void'($urandom(87));
    rst  = 1'b1;
    hold = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    wait_swaps(4);

    // a hold right after a swap keeps the renderer from finishing two frames.
    wait_swaps(1);
    @(posedge clk);
    hold <= 1'b1;
    swaps_before = swap_count;
    repeat (2 * FRAME_CLKS) @(posedge clk);
    check_count++;
    assert (swap_count == swaps_before) else begin
      error_count++;
      $display("[ERROR] swap count under hold: got 0x%0h, expected 0x%0h",
               swap_count, swaps_before);
    end
    hold <= 1'b0;

    swaps_before = swap_count;
    repeat (5 * FRAME_CLKS) begin
      @(posedge clk);
      hold <= 1'($urandom % 2);
    end
    @(posedge clk);
    hold <= 1'b0;
    check_count++;
    assert (swap_count > swaps_before) else begin
      error_count++;
      $display("no frame was swapped in while hold toggled at random");
    end
    wait_swaps(1);
    repeat (FRAME_CLKS) @(posedge clk);

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #((FRAMES_TESTED + 2) * FRAME_CLKS * CLK_NS);
    $display("timeout: the test sequence did not finish in time");
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+design
design/fb_pkg.sv
design/mem_port_if.sv
design/pattern_renderer.sv
design/scanout.sv
design/frame_swapper.sv
design/dbuf_display.sv
tests/sram_model.sv
tests/dbuf_display_properties.sv
tests/dbuf_display_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 --top-module dbuf_display_tb \
  -f filelist.f -o dbuf_display_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/dbuf_display_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$log"; then
  exit 1
fi
exit 0
